/* Makefile */
.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f compile.f --top-module tb_cpu_top

sim:
	verilator --binary --timing -j 0 -f compile.f --top-module tb_cpu_top -Mdir obj_dir
	out=$$(./obj_dir/Vtb_cpu_top); echo "$$out"; echo "$$out" | grep -q "TESTBENCH PASSED"

clean:
	rm -rf obj_dir

/* alu.sv */
`timescale 1ns/1ns

module alu (
  input  logic [cpu_pkg::DATA_W-1:0] src1,
  input  logic [cpu_pkg::DATA_W-1:0] src2,
  input  cpu_pkg::decode_t          dec,
  output logic [cpu_pkg::DATA_W-1:0] result
);
  import cpu_pkg::*;

  alu_op_e    op;
  logic [4:0] shamt;

  assign shamt = src2[4:0];

  // Immediate and memory forms reuse the R-type datapath
  always_comb begin
    case (dec.opcode)
      OP_ADDI, OP_LW, OP_SW, OP_MOVI: op = ADD;
      OP_ORI:                         op = OR;
      default:                        op = dec.alu_op;
    endcase
  end

  always_comb begin
    case (op)
      ADD:     result = src1 + src2;
      SUB:     result = src1 - src2;
      AND:     result = src1 & src2;
      OR:      result = src1 | src2;
      XOR:     result = src1 ^ src2;
      SLL:     result = src1 << shamt;
      SRL:     result = src1 >> shamt;
      SRA:     result = $signed(src1) >>> shamt;
      default: result = '0;
    endcase
  end

endmodule

/* boot_loader.sv */
`timescale 1ns/1ns

module boot_loader (
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          system_enable,
  input  logic [cpu_pkg::DATA_W-1:0]     rom_out,
  output logic                          rom_enable,
  output logic                          rom_read,
  output logic [cpu_pkg::ROM_ADDR_W-1:0] rom_address,
  output logic                          load_done,
  mem_if.target                         core_im,
  mem_if.initiator                      im_bus
);
  import cpu_pkg::*;

  typedef enum logic [1:0] {
    BL_IDLE,
    BL_LOAD,
    BL_DONE
  } bl_state_e;

  bl_state_e             state;
  // Extra top bit marks that all ROM words have been read
  logic [ROM_ADDR_W:0]   rd_cnt;
  logic                  wr_pending;
  logic [ROM_ADDR_W-1:0] wr_addr;
  logic                  last_write;
  logic                  done;

  assign done        = (state == BL_DONE);
  assign load_done   = done;
  assign rom_read    = (state == BL_LOAD) && !rd_cnt[ROM_ADDR_W];
  assign rom_enable  = rom_read;
  assign rom_address = rd_cnt[ROM_ADDR_W-1:0];

  // Copy ends on the first HALT word or on the last ROM word
  assign last_write = wr_pending && ((rom_out[30:25] == OP_HALT) || (&wr_addr));

  always_ff @(posedge clk) begin
    if (rst) begin
      state      <= BL_IDLE;
      rd_cnt     <= '0;
      wr_pending <= 1'b0;
    end else begin
      case (state)
        BL_IDLE: begin
          if (system_enable) state <= BL_LOAD;
        end
        BL_LOAD: begin
          if (rom_read) rd_cnt <= rd_cnt + 1'b1;
          wr_pending <= rom_read && !last_write;
          if (last_write) state <= BL_DONE;
        end
        default: state <= state;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (rom_read) wr_addr <= rom_address;
  end

  // IM port belongs to the core once loading is finished
  assign im_bus.enable = done ? core_im.enable : wr_pending;
  assign im_bus.read   = done ? core_im.read   : 1'b0;
  assign im_bus.write  = done ? core_im.write  : wr_pending;
  assign im_bus.addr   = done ? core_im.addr   : {{(IM_ADDR_W-ROM_ADDR_W){1'b0}}, wr_addr};
  assign im_bus.wdata  = done ? core_im.wdata  : rom_out;
  assign core_im.rdata = im_bus.rdata;

endmodule

/* compile.f */
+incdir+.
cpu_pkg.sv
mem_if.sv
boot_loader.sv
control_unit.sv
regfile.sv
alu.sv
operand_select.sv
cpu_top.sv
tb_cpu_top.sv

/* control_unit.sv */
`timescale 1ns/1ns

module control_unit (
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          load_done,
  input  logic [cpu_pkg::DATA_W-1:0]     alu_result,
  input  logic [cpu_pkg::DATA_W-1:0]     read_data2,
  output cpu_pkg::decode_t              dec,
  output logic [cpu_pkg::REG_ADDR_W-1:0] read_address1,
  output logic [cpu_pkg::REG_ADDR_W-1:0] read_address2,
  output logic [cpu_pkg::REG_ADDR_W-1:0] write_address,
  output logic                          reg_write,
  output logic                          dm_enable,
  output logic                          dm_read,
  output logic                          dm_write,
  output logic [cpu_pkg::DM_ADDR_W-1:0]  dm_address,
  output logic [cpu_pkg::DATA_W-1:0]     dm_in,
  output logic [cpu_pkg::CNT_W-1:0]      cycle_cnt,
  output logic [cpu_pkg::CNT_W-1:0]      ins_cnt,
  output logic                          halted,
  mem_if.initiator                      im
);
  import cpu_pkg::*;

  cu_state_e            state;
  cu_state_e            state_next;
  logic [IM_ADDR_W-1:0] pc;
  logic [DATA_W-1:0]    ir;
  logic [DATA_W-1:0]    alu_q;
  opcode_e              opcode;
  logic                 last_cycle;

  assign opcode = opcode_e'(ir[30:25]);

  always_comb begin
    dec.opcode      = opcode;
    dec.alu_op      = alu_op_e'(ir[4:0]);
    dec.imm20       = ir[19:0];
    dec.imm_sel     = IMM_SEXT15;
    dec.use_imm     = 1'b1;
    dec.wb_from_mem = 1'b0;
    case (opcode)
      OP_ALU:  dec.use_imm = 1'b0;
      OP_ORI:  dec.imm_sel = IMM_ZEXT15;
      OP_MOVI: dec.imm_sel = IMM_SEXT20;
      OP_LW:   dec.wb_from_mem = 1'b1;
      default: ;
    endcase
  end

  assign read_address1 = ir[19:15];
  // SW reads its store data through rt
  assign read_address2 = (opcode == OP_SW) ? ir[24:20] : ir[14:10];
  assign write_address = ir[24:20];
  assign reg_write     = (state == S_WRITEBACK);

  always_comb begin
    state_next = state;
    case (state)
      S_IDLE: begin
        if (load_done) state_next = S_FETCH;
      end
      S_FETCH:  state_next = S_DECODE;
      S_DECODE: state_next = S_EXECUTE;
      S_EXECUTE: begin
        if (opcode == OP_HALT) state_next = S_HALT;
        else if (opcode == OP_LW || opcode == OP_SW) state_next = S_MEMORY;
        else state_next = S_WRITEBACK;
      end
      S_MEMORY: begin
        state_next = (opcode == OP_LW) ? S_WRITEBACK : S_FETCH;
      end
      S_WRITEBACK: state_next = S_FETCH;
      default:     state_next = S_HALT;
    endcase
  end

  assign last_cycle = (state == S_WRITEBACK)
                   || (state == S_MEMORY && opcode == OP_SW)
                   || (state == S_EXECUTE && opcode == OP_HALT);

  always_ff @(posedge clk) begin
    if (rst) begin
      state     <= S_IDLE;
      pc        <= '0;
      cycle_cnt <= '0;
      ins_cnt   <= '0;
    end else begin
      state <= state_next;
      if (state == S_DECODE) pc <= pc + 1'b1;
      if (state != S_IDLE && state != S_HALT) cycle_cnt <= cycle_cnt + 1'b1;
      if (last_cycle) ins_cnt <= ins_cnt + 1'b1;
    end
  end

  // IM data arrives in decode and the DM address is kept at the end of execute
  always_ff @(posedge clk) begin
    if (state == S_DECODE) ir <= im.rdata;
    if (state == S_EXECUTE) alu_q <= alu_result;
  end

  assign im.enable = (state == S_FETCH);
  assign im.read   = (state == S_FETCH);
  assign im.write  = 1'b0;
  assign im.addr   = pc;
  assign im.wdata  = '0;

  assign dm_read    = (state == S_MEMORY) && (opcode == OP_LW);
  assign dm_write   = (state == S_MEMORY) && (opcode == OP_SW);
  assign dm_enable  = dm_read || dm_write;
  assign dm_address = alu_q[DM_ADDR_W-1:0];
  assign dm_in      = read_data2;

  assign halted = (state == S_HALT);

endmodule

/* cpu_pkg.sv */
package cpu_pkg;

  localparam int DATA_W     = 32;
  localparam int IM_ADDR_W  = 10;
  localparam int DM_ADDR_W  = 12;
  localparam int ROM_ADDR_W = 8;
  localparam int REG_ADDR_W = 5;
  localparam int CNT_W      = 64;

  // Major opcode in instruction bits 30:25
  typedef enum logic [5:0] {
    OP_LW   = 6'b000010,
    OP_SW   = 6'b001010,
    OP_ALU  = 6'b100000,
    OP_MOVI = 6'b100010,
    OP_ADDI = 6'b101000,
    OP_ORI  = 6'b101100,
    OP_HALT = 6'b111111
  } opcode_e;

  // Sub-opcode of OP_ALU in instruction bits 4:0
  typedef enum logic [4:0] {
    ADD = 5'b00000,
    SUB = 5'b00001,
    AND = 5'b00010,
    XOR = 5'b00011,
    OR  = 5'b00100,
    SLL = 5'b01100,
    SRL = 5'b01101,
    SRA = 5'b01110
  } alu_op_e;

  typedef enum logic [2:0] {
    S_IDLE,
    S_FETCH,
    S_DECODE,
    S_EXECUTE,
    S_MEMORY,
    S_WRITEBACK,
    S_HALT
  } cu_state_e;

  typedef enum logic [1:0] {
    IMM_SEXT15,
    IMM_ZEXT15,
    IMM_SEXT20
  } imm_sel_e;

  typedef struct packed {
    opcode_e     opcode;
    alu_op_e     alu_op;
    imm_sel_e    imm_sel;
    logic        use_imm;
    logic        wb_from_mem;
    logic [19:0] imm20;
  } decode_t;

endpackage

/* cpu_top.sv */
`timescale 1ns/1ns

module cpu_top (
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          system_enable,
  input  logic [cpu_pkg::DATA_W-1:0]     rom_out,
  input  logic [cpu_pkg::DATA_W-1:0]     instruction,
  input  logic [cpu_pkg::DATA_W-1:0]     dm_out,
  output logic                          rom_enable,
  output logic                          rom_read,
  output logic [cpu_pkg::ROM_ADDR_W-1:0] rom_address,
  output logic                          im_enable,
  output logic                          im_read,
  output logic                          im_write,
  output logic [cpu_pkg::IM_ADDR_W-1:0]  im_address,
  output logic [cpu_pkg::DATA_W-1:0]     im_in,
  output logic                          dm_enable,
  output logic                          dm_read,
  output logic                          dm_write,
  output logic [cpu_pkg::DM_ADDR_W-1:0]  dm_address,
  output logic [cpu_pkg::DATA_W-1:0]     dm_in,
  output logic [cpu_pkg::CNT_W-1:0]      cycle_cnt,
  output logic [cpu_pkg::CNT_W-1:0]      ins_cnt,
  output logic                          halted
);
  import cpu_pkg::*;

  decode_t               dec;
  logic                  load_done;
  logic [REG_ADDR_W-1:0] read_address1;
  logic [REG_ADDR_W-1:0] read_address2;
  logic [REG_ADDR_W-1:0] write_address;
  logic                  reg_write;
  logic [DATA_W-1:0]     read_data1;
  logic [DATA_W-1:0]     read_data2;
  logic [DATA_W-1:0]     write_data;
  logic [DATA_W-1:0]     src1;
  logic [DATA_W-1:0]     src2;
  logic [DATA_W-1:0]     alu_result;

  // Core side and external side of the shared IM port
  mem_if core_im_if ();
  mem_if im_bus_if ();

  assign im_enable       = im_bus_if.enable;
  assign im_read         = im_bus_if.read;
  assign im_write        = im_bus_if.write;
  assign im_address      = im_bus_if.addr;
  assign im_in           = im_bus_if.wdata;
  assign im_bus_if.rdata = instruction;

  boot_loader boot_loader_inst (
    .clk           (clk),
    .rst           (rst),
    .system_enable (system_enable),
    .rom_out       (rom_out),
    .rom_enable    (rom_enable),
    .rom_read      (rom_read),
    .rom_address   (rom_address),
    .load_done     (load_done),
    .core_im       (core_im_if.target),
    .im_bus        (im_bus_if.initiator)
  );

  control_unit control_unit_inst (
    .clk           (clk),
    .rst           (rst),
    .load_done     (load_done),
    .alu_result    (alu_result),
    .read_data2    (read_data2),
    .dec           (dec),
    .read_address1 (read_address1),
    .read_address2 (read_address2),
    .write_address (write_address),
    .reg_write     (reg_write),
    .dm_enable     (dm_enable),
    .dm_read       (dm_read),
    .dm_write      (dm_write),
    .dm_address    (dm_address),
    .dm_in         (dm_in),
    .cycle_cnt     (cycle_cnt),
    .ins_cnt       (ins_cnt),
    .halted        (halted),
    .im            (core_im_if.initiator)
  );

  regfile regfile_inst (
    .clk           (clk),
    .rst           (rst),
    .read_address1 (read_address1),
    .read_address2 (read_address2),
    .write_address (write_address),
    .write_data    (write_data),
    .write         (reg_write),
    .read_data1    (read_data1),
    .read_data2    (read_data2)
  );

  operand_select operand_select_inst (
    .dec        (dec),
    .read_data1 (read_data1),
    .read_data2 (read_data2),
    .alu_result (alu_result),
    .dm_out     (dm_out),
    .src1       (src1),
    .src2       (src2),
    .write_data (write_data)
  );

  alu alu_inst (
    .src1   (src1),
    .src2   (src2),
    .dec    (dec),
    .result (alu_result)
  );

endmodule

/* mem_if.sv */
`timescale 1ns/1ns

// One synchronous memory port with read data one cycle after the read strobe
interface mem_if;
  import cpu_pkg::*;

  logic                 enable;
  logic                 read;
  logic                 write;
  logic [IM_ADDR_W-1:0] addr;
  logic [DATA_W-1:0]    wdata;
  logic [DATA_W-1:0]    rdata;

  modport initiator (
    output enable, read, write, addr, wdata,
    input  rdata
  );

  modport target (
    input  enable, read, write, addr, wdata,
    output rdata
  );
endinterface

/* operand_select.sv */
`timescale 1ns/1ns

module operand_select (
  input  cpu_pkg::decode_t          dec,
  input  logic [cpu_pkg::DATA_W-1:0] read_data1,
  input  logic [cpu_pkg::DATA_W-1:0] read_data2,
  input  logic [cpu_pkg::DATA_W-1:0] alu_result,
  input  logic [cpu_pkg::DATA_W-1:0] dm_out,
  output logic [cpu_pkg::DATA_W-1:0] src1,
  output logic [cpu_pkg::DATA_W-1:0] src2,
  output logic [cpu_pkg::DATA_W-1:0] write_data
);
  import cpu_pkg::*;

  logic [DATA_W-1:0] imm;

  always_comb begin
    case (dec.imm_sel)
      IMM_ZEXT15: imm = {{(DATA_W-15){1'b0}}, dec.imm20[14:0]};
      IMM_SEXT20: imm = {{(DATA_W-20){dec.imm20[19]}}, dec.imm20};
      default:    imm = {{(DATA_W-15){dec.imm20[14]}}, dec.imm20[14:0]};
    endcase
  end

  // MOVI is computed as 0 + imm
  assign src1 = (dec.opcode == OP_MOVI) ? '0 : read_data1;
  assign src2 = dec.use_imm ? imm : read_data2;

  assign write_data = dec.wb_from_mem ? dm_out : alu_result;

endmodule

/* regfile.sv */
`timescale 1ns/1ns

module regfile (
  input  logic                          clk,
  input  logic                          rst,
  input  logic [cpu_pkg::REG_ADDR_W-1:0] read_address1,
  input  logic [cpu_pkg::REG_ADDR_W-1:0] read_address2,
  input  logic [cpu_pkg::REG_ADDR_W-1:0] write_address,
  input  logic [cpu_pkg::DATA_W-1:0]     write_data,
  input  logic                          write,
  output logic [cpu_pkg::DATA_W-1:0]     read_data1,
  output logic [cpu_pkg::DATA_W-1:0]     read_data2
);
  import cpu_pkg::*;

  logic [DATA_W-1:0] regs [2**REG_ADDR_W];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < 2**REG_ADDR_W; i++) regs[i] <= '0;
    end else if (write) begin
      regs[write_address] <= write_data;
    end
  end

  assign read_data1 = regs[read_address1];
  assign read_data2 = regs[read_address2];

endmodule

/* tb_cpu_model.svh */
`ifndef TB_CPU_MODEL_SVH
`define TB_CPU_MODEL_SVH

function automatic logic [31:0] sext15(input logic [31:0] ins);
  return {{17{ins[14]}}, ins[14:0]};
endfunction

function automatic logic [31:0] alu_model(input logic [4:0] op, input logic [31:0] a,
                                          input logic [31:0] b);
  case (op)
    ADD:     return a + b;
    SUB:     return a - b;
    AND:     return a & b;
    OR:      return a | b;
    XOR:     return a ^ b;
    SLL:     return a << b[4:0];
    SRL:     return a >> b[4:0];
    SRA:     return $signed(a) >>> b[4:0];
    default: return '0;
  endcase
endfunction

// Cycles per instruction class
function automatic logic [63:0] cycles_for(input logic [5:0] op);
  if (op == OP_LW) return 64'd5;
  if (op == OP_HALT) return 64'd3;
  return 64'd4;
endfunction

// Runs the ROM image and records the stores in program order
task automatic run_model();
  logic [31:0] ins;
  logic [31:0] a;
  logic [31:0] ea;
  logic [4:0]  rt;
  logic [4:0]  ra;
  logic [4:0]  rb;
  for (int i = 0; i < 32; i++) mrf[i] = '0;
  exp_cycles = '0;
  for (int pc = 0; pc < PROG_LEN; pc++) begin
    ins = rom[pc];
    rt  = ins[24:20];
    ra  = ins[19:15];
    rb  = ins[14:10];
    a   = mrf[ra];
    ea  = a + sext15(ins);
    case (ins[30:25])
      OP_ALU:  mrf[rt] = alu_model(ins[4:0], a, mrf[rb]);
      OP_ADDI: mrf[rt] = ea;
      OP_ORI:  mrf[rt] = a | {17'd0, ins[14:0]};
      OP_MOVI: mrf[rt] = {{12{ins[19]}}, ins[19:0]};
      OP_LW:   mrf[rt] = mdm[ea[11:0]];
      OP_SW: begin
        mdm[ea[11:0]] = mrf[rt];
        exp_addr.push_back(ea[11:0]);
        exp_data.push_back(mrf[rt]);
      end
      default: ;
    endcase
    exp_cycles = exp_cycles + cycles_for(ins[30:25]);
  end
endtask

`endif

/* tb_cpu_top.sv */
`timescale 1ns/1ns

module tb_cpu_top;
  import cpu_pkg::*;

  localparam int N_RAND   = 40;
  localparam int PROG_LEN = N_RAND + 33;
  localparam alu_op_e ALU_OPS [8] = '{ADD, SUB, AND, OR, XOR, SLL, SRL, SRA};

  logic                  clk = 1'b0;
  logic                  rst;
  logic                  system_enable;
  logic [DATA_W-1:0]     rom_out = '0;
  logic [DATA_W-1:0]     instruction = '0;
  logic [DATA_W-1:0]     dm_out = '0;
  logic                  rom_enable;
  logic                  rom_read;
  logic [ROM_ADDR_W-1:0] rom_address;
  logic                  im_enable;
  logic                  im_read;
  logic                  im_write;
  logic [IM_ADDR_W-1:0]  im_address;
  logic [DATA_W-1:0]     im_in;
  logic                  dm_enable;
  logic                  dm_read;
  logic                  dm_write;
  logic [DM_ADDR_W-1:0]  dm_address;
  logic [DATA_W-1:0]     dm_in;
  logic [CNT_W-1:0]      cycle_cnt;
  logic [CNT_W-1:0]      ins_cnt;
  logic                  halted;
  logic                  any_strobe;

  logic [31:0] lfsr;
  logic [31:0] rom [256];
  logic [31:0] im_mem [1024];
  logic [31:0] dm_mem [4096];
  logic [31:0] mrf [32];
  logic [31:0] mdm [4096];
  logic [11:0] exp_addr [$];
  logic [31:0] exp_data [$];
  logic [63:0] exp_cycles;
  int          value_errs = 0;
  int          other_errs = 0;
  int          im_writes = 0;

  `include "tb_cpu_model.svh"

  cpu_top cpu_top_inst (.*);

  assign any_strobe = rom_enable | rom_read | im_enable | im_read | im_write
                    | dm_enable | dm_read | dm_write;

  always #5 clk = ~clk;

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
      v = {v[30:0], lfsr[0]};
    end
    return v;
  endfunction

  function automatic logic [31:0] dm_fill(input int a);
    logic [11:0] w;
    w = a[11:0];
    return {w ^ 12'ha5c, 8'h3c, w};
  endfunction

  // Random body, then a register dump to DM 3840+i and a final HALT
  task automatic build_program();
    logic [31:0] cls;
    logic [31:0] r;
    logic [4:0]  rt;
    logic [4:0]  ra;
    logic [4:0]  rb;
    for (int i = 0; i < 256; i++) rom[i] = {8'h5a, 8'(i), 8'hc3, 8'(i)};
    for (int i = 0; i < N_RAND; i++) begin
      cls = rand_bits(5);
      r   = rand_bits(15);
      // r0 stays zero so the dump addresses are fixed
      rt  = (r[4:0] == 5'd0) ? 5'd1 : r[4:0];
      ra  = r[9:5];
      rb  = r[14:10];
      r   = rand_bits(20);
      if (cls < 3) rom[i] = {1'b0, OP_SW, rt, ra, 7'd0, r[7:0]};
      else if (cls < 7) rom[i] = {1'b0, OP_LW, rt, ra, 7'd0, r[7:0]};
      else if (cls < 21) rom[i] = {1'b0, OP_ALU, rt, ra, rb, 5'd0, ALU_OPS[r[2:0]]};
      else if (cls < 25) rom[i] = {1'b0, OP_ADDI, rt, ra, r[14:0]};
      else if (cls < 28) rom[i] = {1'b0, OP_ORI, rt, ra, r[14:0]};
      else rom[i] = {1'b0, OP_MOVI, rt, r[19:0]};
    end
    for (int i = 0; i < 32; i++) rom[N_RAND + i] = {1'b0, OP_SW, 5'(i), 5'd0, 15'(3840 + i)};
    rom[PROG_LEN - 1] = {1'b0, OP_HALT, 25'd0};
  endtask

  // ROM, IM and DM models answer one cycle after the strobe
  always @(posedge clk) begin
    logic [31:0] rom_q;
    logic [31:0] im_q;
    logic [31:0] dm_q;
    rom_q = rom_out;
    im_q  = instruction;
    dm_q  = dm_out;
    if (!rst && !system_enable && any_strobe) begin
      other_errs++;
      $display("memory strobe seen before system_enable rose, at %0t", $time);
    end
    if (rom_enable && rom_read) rom_q = rom[rom_address];
    if (im_enable && im_write) begin
      im_writes++;
      if (load_done_seen()) begin
        other_errs++;
        $display("IM write seen after load_done, at %0t", $time);
      end else if (int'(im_address) >= PROG_LEN) begin
        other_errs++;
        $display("IM write to %0d beyond the HALT word, at %0t", im_address, $time);
      end else if (im_in !== rom[im_address[ROM_ADDR_W-1:0]]) begin
        value_errs++;
        $display("error at %0t: IM[%0d] written %h, expected %h", $time, im_address, im_in,
                 rom[im_address[ROM_ADDR_W-1:0]]);
      end
      im_mem[im_address] = im_in;
    end
    if (im_enable && im_read) im_q = im_mem[im_address];
    if (dm_enable && dm_write) begin
      if (exp_addr.size() == 0) begin
        other_errs++;
        $display("DM store to %0d seen when no store was expected, at %0t", dm_address, $time);
      end else if (dm_address !== exp_addr[0] || dm_in !== exp_data[0]) begin
        value_errs++;
        $display("error at %0t: DM store %0d <= %h, expected %0d <= %h", $time, dm_address,
                 dm_in, exp_addr[0], exp_data[0]);
      end
      if (exp_addr.size() != 0) begin
        void'(exp_addr.pop_front());
        void'(exp_data.pop_front());
      end
      dm_mem[dm_address] = dm_in;
    end
    if (dm_enable && dm_read) dm_q = dm_mem[dm_address];
    #1;
    rom_out     <= rom_q;
    instruction <= im_q;
    dm_out      <= dm_q;
  end

  function automatic logic load_done_seen();
    return cpu_top_inst.load_done;
  endfunction

  initial begin
    repeat (200 + 6 * PROG_LEN) @(posedge clk);
    $display("timeout: halted did not rise within %0d cycles", 200 + 6 * PROG_LEN);
    $display("TESTBENCH FAILED");
    $finish;
  end

  initial begin
    logic [63:0] cyc_q;
    logic [63:0] ins_q;
    rst           = 1'b1;
    system_enable = 1'b0;
    lfsr          = 32'h0ce8cd85;
    for (int a = 0; a < 4096; a++) begin
      dm_mem[a] = dm_fill(a);
      mdm[a]    = dm_fill(a);
    end
    build_program();
    run_model();
    repeat (5) @(posedge clk);
    #1 rst = 1'b0;
    repeat (20) @(posedge clk);
    #1 system_enable = 1'b1;
    while (halted !== 1'b1) @(posedge clk);
    if (ins_cnt !== 64'(PROG_LEN)) begin
      value_errs++;
      $display("error at %0t: ins_cnt %0d, expected %0d", $time, ins_cnt, PROG_LEN);
    end
    if (cycle_cnt !== exp_cycles) begin
      value_errs++;
      $display("error at %0t: cycle_cnt %0d, expected %0d", $time, cycle_cnt, exp_cycles);
    end
    cyc_q = cycle_cnt;
    ins_q = ins_cnt;
    // Core must stay frozen once halted
    repeat (20) begin
      @(posedge clk);
      if (cycle_cnt !== cyc_q || ins_cnt !== ins_q) begin
        value_errs++;
        $display("error at %0t: counters moved after halt (%0d, %0d)", $time, cycle_cnt,
                 ins_cnt);
      end
      if (any_strobe) begin
        other_errs++;
        $display("memory strobe seen after halt, at %0t", $time);
      end
    end
    if (im_writes != PROG_LEN) begin
      other_errs++;
      $display("boot wrote %0d IM words instead of %0d", im_writes, PROG_LEN);
    end
    if (exp_addr.size() != 0) begin
      other_errs++;
      $display("%0d expected DM stores never happened", exp_addr.size());
    end
    $display("error count: %0d wrong values, %0d other failures", value_errs, other_errs);
    if (value_errs == 0 && other_errs == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule
